//--- project.f
source/ecc_sram_pkg.sv
source/secded_encoder.sv
source/secded_decoder.sv
source/sram_1rw.sv
source/sram_ecc_1rw.sv
source/ecc_err_ctrl.sv
source/ecc_sram_top.sv
sim/tb_clk_gen.sv
sim/ecc_sram_checker.sv
sim/ecc_sram_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the ecc sram testbench with verilator, run it and scan the log for the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ecc_sram_tb -f project.f \
    -o ecc_sram_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/ecc_sram_sim > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/ecc_sram_tb.sv
// ecc sram testbench covering clean traffic, error injection, one-shot mode and registers
`default_nettype none
`timescale 1ns/1ps

module ecc_sram_tb;
    import ecc_sram_pkg::*;

    localparam int N_CLEAN          = 32;
    localparam int N_SINGLE         = 16;
    localparam int N_DOUBLE         = 8;
    localparam int PLANNED_ACCESSES = 2*N_CLEAN + 3*N_SINGLE + 3*N_DOUBLE + 40;
    localparam int WATCHDOG_NS      = (PLANNED_ACCESSES + 200) * 8 * 2;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              data_known;   // false once two bits are flipped
        logic              cor;
        logic              unc;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  cs;
    logic                  we;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     rdata;
    logic                  rd_valid;
    logic                  err_cor;
    logic                  err_unc;
    logic                  cfg_we;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_wdata;
    logic [CFG_DATA_W-1:0] cfg_rdata;

    // shadow of what was written and which mask corrupted it
    logic [DATA_W-1:0] shadow_data [DEPTH];
    logic [DATA_W-1:0] shadow_mask [DEPTH];
    expect_t           exp_q [$];

    logic [DATA_W-1:0] model_mask;
    logic              model_inj_en;
    logic              model_inj_once;

    int tb_errors;
    int tb_checks;
    int cmp_errors;
    int cmp_checks;

    tb_clk_gen clk_gen_inst (.clk);

    ecc_sram_top ecc_sram_top_inst (
        .clk, .rst, .cs, .we, .addr, .wdata, .rdata, .rd_valid, .err_cor, .err_unc,
        .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata
    );

    // expected read result from the mask popcount
    function automatic expect_t ref_read(input logic [ADDR_W-1:0] a);
        expect_t e;
        int      ones;
        ones = 0;
        for (int i = 0; i < DATA_W; i++) begin
            if (shadow_mask[a][i]) ones++;
        end
        e.data       = shadow_data[a];
        e.data_known = (ones < 2);
        e.cor        = (ones == 1);
        e.unc        = (ones == 2);
        return e;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic mem_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        cs    = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        shadow_data[a] = d;
        shadow_mask[a] = model_inj_en ? model_mask : '0;
        if (model_inj_en && model_inj_once) model_inj_en = 1'b0;
        @(posedge clk);
        #1;
        cs = 1'b0;
        we = 1'b0;
    endtask

    task automatic mem_read(input logic [ADDR_W-1:0] a);
        cs   = 1'b1;
        we   = 1'b0;
        addr = a;
        exp_q.push_back(ref_read(a));
        @(posedge clk);
        #1;
        cs = 1'b0;
    endtask

    task automatic cfg_write(input logic [CFG_ADDR_W-1:0] a, input logic [CFG_DATA_W-1:0] d);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        if (a == REG_INJ_MASK) model_mask = d;
        if (a == REG_CTRL) begin
            model_inj_en   = d[0];
            model_inj_once = d[1];
        end
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic check_reg(input logic [CFG_ADDR_W-1:0] a, input logic [CFG_DATA_W-1:0] exp,
                             input string name);
        cfg_addr = a;
        #2;                                   // cfg_rdata is combinational
        tb_checks++;
        if (cfg_rdata !== exp) begin
            show_mismatch(name, exp, cfg_rdata);
            tb_errors++;
        end
        @(posedge clk);
        #1;
    endtask

    // wait for every issued read to come back, then let the counters settle
    task automatic drain_reads;
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d reads did not return within 20 cycles", exp_q.size());
            tb_errors++;
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int errs_before, inout int run,
                               inout int failed);
        run++;
        if (tb_errors + cmp_errors != errs_before) begin
            failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: PASS", name);
        end
    endtask

    // compare each returning read at the falling edge where outputs are stable
    always @(negedge clk) begin
        expect_t e;
        if (!rst && rd_valid) begin
            if (exp_q.size() == 0) begin
                $display("rd_valid high at %0t with no read outstanding", $time);
                cmp_errors++;
            end else begin
                e = exp_q.pop_front();
                cmp_checks++;
                if (e.data_known && rdata !== e.data) begin
                    show_mismatch("rdata", e.data, rdata);
                    cmp_errors++;
                end
                if (err_cor !== e.cor) begin
                    show_mismatch("err_cor", 32'(e.cor), 32'(err_cor));
                    cmp_errors++;
                end
                if (err_unc !== e.unc) begin
                    show_mismatch("err_unc", 32'(e.unc), 32'(err_unc));
                    cmp_errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int                errs_before;
        int                tests_run;
        int                tests_failed;
        int unsigned       b0;
        int unsigned       b1;
        logic [DATA_W-1:0] m;
        void'($urandom(32'he0f6_93df));
        rst = 1'b1;
        cs = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        model_mask = '0;
        model_inj_en = 1'b0;
        model_inj_once = 1'b0;
        tb_errors = 0;
        tb_checks = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        errs_before = tb_errors + cmp_errors;
        for (int i = 0; i < N_CLEAN; i++) mem_write(ADDR_W'(i), $urandom());
        for (int i = 0; i < N_CLEAN; i++) mem_read(ADDR_W'((i * 7) % N_CLEAN));  // back to back
        drain_reads();
        check_reg(REG_ERR_CNT, 32'h0, "err_cnt");
        finish_test("clean traffic", errs_before, tests_run, tests_failed);

        errs_before = tb_errors + cmp_errors;
        cfg_write(REG_ERR_CNT, '0);
        cfg_write(REG_CTRL, 32'h1);
        for (int i = 0; i < N_SINGLE; i++) begin
            cfg_write(REG_INJ_MASK, 32'(1) << ($urandom() % DATA_W));
            mem_write(ADDR_W'(64 + i), $urandom());
        end
        cfg_write(REG_CTRL, 32'h0);
        for (int i = 0; i < N_SINGLE; i++) mem_read(ADDR_W'(64 + i));
        drain_reads();
        check_reg(REG_ERR_CNT, {16'd0, 16'(N_SINGLE)}, "err_cnt");
        finish_test("single-bit injection", errs_before, tests_run, tests_failed);

        errs_before = tb_errors + cmp_errors;
        cfg_write(REG_ERR_CNT, '0);
        cfg_write(REG_CTRL, 32'h1);
        for (int i = 0; i < N_DOUBLE; i++) begin
            b0 = $urandom() % DATA_W;
            b1 = (b0 + 1 + ($urandom() % (DATA_W - 1))) % DATA_W;   // never equal to b0
            m  = (32'(1) << b0) | (32'(1) << b1);
            cfg_write(REG_INJ_MASK, m);
            mem_write(ADDR_W'(128 + i), $urandom());
        end
        cfg_write(REG_CTRL, 32'h0);
        for (int i = 0; i < N_DOUBLE; i++) mem_read(ADDR_W'(128 + i));
        mem_read(ADDR_W'(0));    // clean read must leave the error address alone
        drain_reads();
        check_reg(REG_ERR_CNT, {16'(N_DOUBLE), 16'd0}, "err_cnt");
        check_reg(REG_ERR_ADDR, 32'(128 + N_DOUBLE - 1), "err_addr");
        finish_test("double-bit injection", errs_before, tests_run, tests_failed);

        errs_before = tb_errors + cmp_errors;
        cfg_write(REG_INJ_MASK, 32'(1) << ($urandom() % DATA_W));
        cfg_write(REG_CTRL, 32'h3);
        check_reg(REG_CTRL, 32'h3, "ctrl");
        mem_write(ADDR_W'(200), $urandom());
        mem_write(ADDR_W'(201), $urandom());    // stored clean after the disarm
        check_reg(REG_CTRL, 32'h2, "ctrl");
        mem_read(ADDR_W'(200));
        mem_read(ADDR_W'(201));
        drain_reads();
        finish_test("one-shot injection", errs_before, tests_run, tests_failed);

        errs_before = tb_errors + cmp_errors;
        cfg_write(REG_ERR_CNT, $urandom());
        check_reg(REG_ERR_CNT, 32'h0, "err_cnt");
        m = $urandom();
        cfg_write(REG_INJ_MASK, m);
        check_reg(REG_INJ_MASK, m, "inj_mask");
        finish_test("register access", errs_before, tests_run, tests_failed);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 tb_checks + cmp_checks, tb_errors + cmp_errors);
        if (tests_failed == 0 && tb_errors + cmp_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/ecc_sram_checker.sv
// ecc sram checker with read timing and error flag assertions on the top-level ports
`default_nettype none
`timescale 1ns/1ps

module ecc_sram_checker (
    input logic clk,
    input logic rst,
    input logic cs,
    input logic we,
    input logic rd_valid,
    input logic err_cor,
    input logic err_unc
);

    // flags are decoded from one syndrome, so at most one can be set
    flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> !(err_cor && err_unc))
        else $error("err_cor and err_unc high together");

    read_returns: assert property (@(posedge clk) disable iff (rst)
        (cs && !we) |=> rd_valid)
        else $error("rd_valid missing one cycle after a read strobe");

    no_spurious_valid: assert property (@(posedge clk) disable iff (rst)
        !(cs && !we) |=> !rd_valid)
        else $error("rd_valid high without a read strobe the cycle before");

    // first cycle out of reset has nothing in flight
    valid_after_reset: assert property (@(posedge clk) rst |=> !rd_valid)
        else $error("rd_valid high in the cycle after reset");

endmodule

bind ecc_sram_top ecc_sram_checker checker_inst (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .we       (we),
    .rd_valid (rd_valid),
    .err_cor  (err_cor),
    .err_unc  (err_unc)
);

`default_nettype wire

//--- sim/tb_clk_gen.sv
// testbench clock generator for a free running 8 ns clock
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // half period
    end

endmodule

`default_nettype wire

//--- source/ecc_sram_top.sv
// ecc sram top joining the ecc protected memory to its error control block
`default_nettype none
`timescale 1ns/1ps

module ecc_sram_top (
    input  logic                                clk,
    input  logic                                rst,

    // memory port
    input  logic                                cs,
    input  logic                                we,
    input  logic [ecc_sram_pkg::ADDR_W-1:0]     addr,
    input  logic [ecc_sram_pkg::DATA_W-1:0]     wdata,
    output logic [ecc_sram_pkg::DATA_W-1:0]     rdata,
    output logic                                rd_valid,
    output logic                                err_cor,
    output logic                                err_unc,

    // register port
    input  logic                                cfg_we,
    input  logic [ecc_sram_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [ecc_sram_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic [ecc_sram_pkg::CFG_DATA_W-1:0] cfg_rdata
);
    import ecc_sram_pkg::*;

    ecc_cfg_t    cfg;
    ecc_status_t status;

    sram_ecc_1rw mem_inst (
        .clk,
        .cs,
        .we,
        .addr,
        .wdata,
        .cfg,
        .rdata,
        .status
    );

    ecc_err_ctrl ctrl_inst (
        .clk,
        .rst,
        .cs,
        .we,
        .addr,
        .cfg_we,
        .cfg_addr,
        .cfg_wdata,
        .status,
        .cfg_rdata,
        .cfg,
        .rd_valid
    );

    // flags hold meaning only while rd_valid is high
    assign err_cor = status.err_cor;
    assign err_unc = status.err_unc;

endmodule

`default_nettype wire

//--- source/ecc_err_ctrl.sv
// ecc error control block with injection registers, error counters and last error address
`default_nettype none
`timescale 1ns/1ps

module ecc_err_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cs,
    input  logic                                we,
    input  logic [ecc_sram_pkg::ADDR_W-1:0]     addr,
    input  logic                                cfg_we,
    input  logic [ecc_sram_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [ecc_sram_pkg::CFG_DATA_W-1:0] cfg_wdata,
    input  ecc_sram_pkg::ecc_status_t           status,
    output logic [ecc_sram_pkg::CFG_DATA_W-1:0] cfg_rdata,
    output ecc_sram_pkg::ecc_cfg_t              cfg,
    output logic                                rd_valid
);
    import ecc_sram_pkg::*;

    logic [DATA_W-1:0] inj_mask;
    logic              inj_en;
    logic              inj_once;
    logic [CNT_W-1:0]  cnt_cor;
    logic [CNT_W-1:0]  cnt_unc;
    logic [ADDR_W-1:0] err_addr;
    logic [ADDR_W-1:0] rd_addr;      // address of the read now returning
    logic              rd_err;

    always_ff @(posedge clk) begin
        if (cfg_we && cfg_addr == REG_INJ_MASK) begin
            inj_mask <= cfg_wdata;
        end
    end

    // a one-shot write disarms at the same edge it is stored
    always_ff @(posedge clk) begin
        if (rst) begin
            inj_en   <= 1'b0;
            inj_once <= 1'b0;
        end else if (cfg_we && cfg_addr == REG_CTRL) begin
            inj_en   <= cfg_wdata[0];
            inj_once <= cfg_wdata[1];
        end else if (inj_en && inj_once && cs && we) begin
            inj_en <= 1'b0;
        end
    end

    // one read in flight per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= cs & ~we;
        end
    end

    always_ff @(posedge clk) begin
        if (cs && !we) begin
            rd_addr <= addr;
        end
    end

    assign rd_err = rd_valid & (status.err_cor | status.err_unc);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_cor  <= '0;
            cnt_unc  <= '0;
            err_addr <= '0;
        end else begin
            if (cfg_we && cfg_addr == REG_ERR_CNT) begin
                cnt_cor <= '0;            // any write value clears
                cnt_unc <= '0;
            end else begin
                if (rd_valid && status.err_cor && cnt_cor != '1) cnt_cor <= cnt_cor + 1'b1;
                if (rd_valid && status.err_unc && cnt_unc != '1) cnt_unc <= cnt_unc + 1'b1;
            end
            if (rd_err) err_addr <= rd_addr;
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_INJ_MASK: cfg_rdata = inj_mask;
            REG_CTRL:     cfg_rdata = {{(CFG_DATA_W-2){1'b0}}, inj_once, inj_en};
            REG_ERR_CNT:  cfg_rdata = {cnt_unc, cnt_cor};
            default:      cfg_rdata = CFG_DATA_W'(err_addr);
        endcase
    end

    assign cfg.inj_en   = inj_en;
    assign cfg.inj_mask = inj_mask;

endmodule

`default_nettype wire

//--- source/sram_ecc_1rw.sv
// ecc memory wrapper that encodes, injects, stores and decodes one 32-bit lane
`default_nettype none
`timescale 1ns/1ps

module sram_ecc_1rw (
    input  logic                            clk,
    input  logic                            cs,
    input  logic                            we,
    input  logic [ecc_sram_pkg::ADDR_W-1:0] addr,
    input  logic [ecc_sram_pkg::DATA_W-1:0] wdata,
    input  ecc_sram_pkg::ecc_cfg_t          cfg,
    output logic [ecc_sram_pkg::DATA_W-1:0] rdata,
    output ecc_sram_pkg::ecc_status_t       status
);
    import ecc_sram_pkg::*;

    logic [CHECK_W-1:0] wcheck;
    logic [DATA_W-1:0]  inj_bits;
    ecc_codeword_u      wcode;
    ecc_codeword_u      rcode;
    logic               dec_cor;
    logic               dec_unc;

    secded_encoder encoder_inst (
        .data  (wdata),
        .check (wcheck)
    );

    // corruption goes into the data field only, after the check bits are formed
    assign inj_bits           = cfg.inj_en ? cfg.inj_mask : '0;
    assign wcode.fields.check = wcheck;
    assign wcode.fields.data  = wdata ^ inj_bits;

    sram_1rw array_inst (
        .clk,
        .cs,
        .we,
        .addr,
        .wdata (wcode),
        .rdata (rcode)
    );

    secded_decoder decoder_inst (
        .code     (rcode),
        .data     (rdata),
        .syndrome (),         // not needed past the decoder
        .err_cor  (dec_cor),
        .err_unc  (dec_unc)
    );

    // status is valid every cycle and the control block decides if a read owns it
    assign status.err_cor = dec_cor;
    assign status.err_unc = dec_unc;

endmodule

`default_nettype wire

//--- source/sram_1rw.sv
// behavioral single-port codeword array with registered read
`default_nettype none
`timescale 1ns/1ps

module sram_1rw (
    input  logic                            clk,
    input  logic                            cs,
    input  logic                            we,
    input  logic [ecc_sram_pkg::ADDR_W-1:0] addr,
    input  logic [ecc_sram_pkg::CODE_W-1:0] wdata,
    output logic [ecc_sram_pkg::CODE_W-1:0] rdata
);
    import ecc_sram_pkg::*;

    logic [CODE_W-1:0] mem [DEPTH];

    // rdata only moves on a read, otherwise it keeps the last word
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/secded_decoder.sv
// secded decoder with syndrome, single-bit correction and error classification
`default_nettype none
`timescale 1ns/1ps

module secded_decoder (
    input  ecc_sram_pkg::ecc_codeword_u      code,
    output logic [ecc_sram_pkg::DATA_W-1:0]  data,
    output logic [ecc_sram_pkg::CHECK_W-1:0] syndrome,
    output logic                             err_cor,
    output logic                             err_unc
);
    import ecc_sram_pkg::*;

    logic [CHECK_W-1:0] check_calc;
    logic [CODE_W-1:0]  flip;
    logic               col_hit;      // syndrome matches a data column
    logic               chk_hit;      // syndrome points at one check bit
    ecc_codeword_u      corrected;

    secded_encoder recompute_inst (
        .data  (code.fields.data),
        .check (check_calc)
    );

    assign syndrome = check_calc ^ code.fields.check;
    assign chk_hit  = $onehot(syndrome);

    // build the flip vector over the whole codeword
    always_comb begin
        flip    = '0;
        col_hit = 1'b0;
        for (int i = 0; i < DATA_W; i++) begin
            if (syndrome == H_COLS[i]) begin
                flip[i] = 1'b1;
                col_hit = 1'b1;
            end
        end
        if (chk_hit) begin
            flip[DATA_W +: CHECK_W] = syndrome;   // flip the failing check bit only
        end
    end

    assign corrected.bits = code.bits ^ flip;
    assign data           = corrected.fields.data;

    // odd-weight columns make every double error an even, non-zero syndrome
    assign err_cor = col_hit | chk_hit;
    assign err_unc = (syndrome != '0) & ~err_cor;

endmodule

`default_nettype wire

//--- source/secded_encoder.sv
// secded encoder making hsiao check bits for one 32-bit data word
`default_nettype none
`timescale 1ns/1ps

module secded_encoder (
    input  logic [ecc_sram_pkg::DATA_W-1:0]  data,
    output logic [ecc_sram_pkg::CHECK_W-1:0] check
);
    import ecc_sram_pkg::*;

    // each data bit contributes its H column to the parity
    always_comb begin
        check = '0;
        for (int i = 0; i < DATA_W; i++) begin
            check ^= H_COLS[i] & {CHECK_W{data[i]}};
        end
    end

endmodule

`default_nettype wire

//--- source/ecc_sram_pkg.sv
// ecc sram package with widths, register map, hsiao H matrix and shared types
`default_nettype none

package ecc_sram_pkg;

    localparam int unsigned ADDR_W  = 8;
    localparam int unsigned DEPTH   = 2**ADDR_W;
    localparam int unsigned DATA_W  = 32;
    localparam int unsigned CHECK_W = 7;
    localparam int unsigned CODE_W  = DATA_W + CHECK_W;

    // register port
    localparam int unsigned CFG_ADDR_W = 2;
    localparam int unsigned CFG_DATA_W = 32;
    localparam int unsigned CNT_W      = 16;     // width of each saturating error counter

    localparam logic [CFG_ADDR_W-1:0] REG_INJ_MASK = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_CTRL     = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_ERR_CNT  = 2'd2;
    localparam logic [CFG_ADDR_W-1:0] REG_ERR_ADDR = 2'd3;   // read only

    // H matrix columns for the data bits are all weight 3 and distinct
    // check bit columns are the unit vectors, so no data column can alias one
    localparam logic [CHECK_W-1:0] H_COLS [0:DATA_W-1] = '{
        7'h07, 7'h0b, 7'h13, 7'h23, 7'h43, 7'h0d, 7'h15, 7'h25,
        7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0e,
        7'h16, 7'h26, 7'h46, 7'h1a, 7'h2a, 7'h4a, 7'h32, 7'h52,
        7'h62, 7'h1c, 7'h2c, 7'h4c, 7'h34, 7'h54, 7'h64, 7'h38
    };

    typedef struct packed {
        logic [CHECK_W-1:0] check;   // upper bits of the stored word
        logic [DATA_W-1:0]  data;
    } ecc_fields_t;

    // one stored word, seen flat for syndrome work or split into fields
    typedef union packed {
        logic [CODE_W-1:0] bits;
        ecc_fields_t       fields;
    } ecc_codeword_u;

    typedef struct packed {
        logic              inj_en;
        logic [DATA_W-1:0] inj_mask;
    } ecc_cfg_t;

    typedef struct packed {
        logic err_cor;
        logic err_unc;
    } ecc_status_t;

endpackage

`default_nettype wire
